// File: verilog.f
common/cpu_pkg.sv
rtl/fetch_stage.sv
decode/decode_ctrl.sv
decode/reg_file.sv
rtl/hazard_unit.sv
execute/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
testbench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Pass or fail is decided by the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	logic        clk;
	logic        reset;
	logic [15:0] instr_data;
	logic [15:0] instr_addr;
	logic        err;
	logic        halted;
	logic        retire_valid;
	logic [2:0]  retire_reg;
	logic [15:0] retire_data;

	logic [15:0] prog [256];
	int          prog_len;
	int          seed;
	int          errors;
	int          checks;
	int          err_cycles;
	logic [2:0]  exp_reg[$];
	logic [15:0] exp_data[$];
	logic [2:0]  got_reg[$];
	logic [15:0] got_data[$];

	cpu_top cpu_top_i (
		.clk          (clk),
		.reset        (reset),
		.instr_data   (instr_data),
		.instr_addr   (instr_addr),
		.err          (err),
		.halted       (halted),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data)
	);

	always #4 clk = ~clk;

	// Instruction memory model answers the PC half a cycle later
	always @(negedge clk) begin
		instr_data = prog[instr_addr[8:1]];
	end

	function automatic logic [15:0] alu_word(input logic [2:0] rs, input logic [2:0] rt,
		input logic [2:0] rd, input logic [1:0] fn);
		return {cpu_pkg::OP_ALU, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] imm5_word(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] imm8_word(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic clear_program();
		for (int i = 0; i < 256; i++)
			prog[i] = {cpu_pkg::OP_HALT, 11'd0};
		prog_len = 0;
	endtask

	task automatic put_instr(input logic [15:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic check_true(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	// Architectural model runs one instruction per step in program order
	task automatic run_model();
		logic [15:0] regs [8];
		logic [15:0] dmem [256];
		logic [15:0] pc;
		logic [15:0] word;
		logic [15:0] s5;
		logic [15:0] s8;
		logic [15:0] va;
		logic [15:0] vb;
		logic [15:0] addr;
		logic [2:0]  wr_reg;
		logic [15:0] wr_val;
		bit          wr_en;
		bit          done;
		int          steps;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = '0;
		exp_reg.delete();
		exp_data.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 500) begin
			word = prog[pc[8:1]];
			s5 = {{11{word[4]}}, word[4:0]};
			s8 = {{8{word[7]}}, word[7:0]};
			va = regs[word[10:8]];
			vb = regs[word[7:5]];
			addr = va + s5;
			wr_en = 1'b0;
			wr_reg = word[7:5];
			wr_val = '0;
			pc = pc + 16'd2;
			case (word[15:11])
				cpu_pkg::OP_HALT: done = 1'b1;
				cpu_pkg::OP_ADDI: begin
					wr_en = 1'b1;
					wr_val = va + s5;
				end
				cpu_pkg::OP_LBI: begin
					wr_en = 1'b1;
					wr_reg = word[10:8];
					wr_val = s8;
				end
				cpu_pkg::OP_ST: dmem[addr[8:1]] = vb;
				cpu_pkg::OP_LD: begin
					wr_en = 1'b1;
					wr_val = dmem[addr[8:1]];
				end
				cpu_pkg::OP_BEQZ: if (va == 16'd0) pc = pc + s8;
				cpu_pkg::OP_BNEZ: if (va != 16'd0) pc = pc + s8;
				cpu_pkg::OP_ALU: begin
					wr_en = 1'b1;
					wr_reg = word[4:2];
					case (word[1:0])
						2'b00:   wr_val = va + vb;
						2'b01:   wr_val = vb - va;
						2'b10:   wr_val = va ^ vb;
						default: wr_val = va & ~vb;
					endcase
				end
				// NOP and unsupported opcodes change nothing
				default: wr_en = 1'b0;
			endcase
			if (wr_en) begin
				regs[wr_reg] = wr_val;
				exp_reg.push_back(wr_reg);
				exp_data.push_back(wr_val);
			end
			steps++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic sample_outputs();
		if (retire_valid) begin
			got_reg.push_back(retire_reg);
			got_data.push_back(retire_data);
		end
		if (err)
			err_cycles++;
	endtask

	task automatic run_and_check(input string name, input bit expect_err);
		int          cycles;
		logic [15:0] addr_at_halt;
		run_model();
		got_reg.delete();
		got_data.delete();
		err_cycles = 0;
		apply_reset();
		check_true(!halted && instr_addr == 16'd0 && !retire_valid,
			$sformatf("%s: state after reset is halted=%b pc=%h", name, halted, instr_addr));
		cycles = 0;
		while (!halted && cycles < 200) begin
			@(negedge clk);
			sample_outputs();
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("%s: halted never rose within 200 cycles", name);
			return;
		end
		// Once halted, the PC freezes and nothing more retires
		addr_at_halt = instr_addr;
		repeat (8) begin
			@(negedge clk);
			sample_outputs();
			check_true(halted, $sformatf("%s: halted dropped", name));
			check_true(instr_addr == addr_at_halt,
				$sformatf("%s: pc moved to %h after halt", name, instr_addr));
		end
		check_true(got_reg.size() == exp_reg.size(),
			$sformatf("%s: %0d writes retired, model %0d",
			name, got_reg.size(), exp_reg.size()));
		for (int i = 0; i < exp_reg.size() && i < got_reg.size(); i++)
			check_true(got_reg[i] == exp_reg[i] && got_data[i] == exp_data[i],
				$sformatf("%s: write %0d is r%0d=%h, model r%0d=%h", name, i,
				got_reg[i], got_data[i], exp_reg[i], exp_data[i]));
		check_true(expect_err ? err_cycles > 0 : err_cycles == 0,
			$sformatf("%s: err high for %0d cycles", name, err_cycles));
	endtask

	task automatic alu_chain();
		logic [7:0] v;
		clear_program();
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd1, rand_byte()));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd2, rand_byte()));
		put_instr(alu_word(3'd1, 3'd2, 3'd3, cpu_pkg::FN_ADD));
		put_instr(alu_word(3'd3, 3'd1, 3'd4, cpu_pkg::FN_SUB));
		put_instr(alu_word(3'd4, 3'd3, 3'd5, cpu_pkg::FN_XOR));
		put_instr(alu_word(3'd5, 3'd4, 3'd6, cpu_pkg::FN_ANDN));
		v = rand_byte();
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd6, 3'd7, v[4:0]));
		v = rand_byte();
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd7, 3'd7, v[4:0]));
		put_instr(alu_word(3'd7, 3'd5, 3'd0, cpu_pkg::FN_ADD));
		put_instr(alu_word(3'd0, 3'd6, 3'd1, cpu_pkg::FN_SUB));
		run_and_check("alu chain", 1'b0);
	endtask

	task automatic store_load();
		clear_program();
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd1, 8'h20));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd2, rand_byte()));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd3, rand_byte()));
		put_instr(imm5_word(cpu_pkg::OP_ST, 3'd1, 3'd2, 5'd0));
		put_instr(imm5_word(cpu_pkg::OP_ST, 3'd1, 3'd3, 5'd2));
		put_instr(imm5_word(cpu_pkg::OP_ST, 3'd1, 3'd1, 5'h1c));
		// Each load is used by the very next instruction
		put_instr(imm5_word(cpu_pkg::OP_LD, 3'd1, 3'd4, 5'd0));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd4, 3'd5, 5'd0));
		put_instr(imm5_word(cpu_pkg::OP_LD, 3'd1, 3'd6, 5'd2));
		put_instr(alu_word(3'd6, 3'd5, 3'd7, cpu_pkg::FN_SUB));
		put_instr(imm5_word(cpu_pkg::OP_LD, 3'd1, 3'd4, 5'h1c));
		put_instr(alu_word(3'd7, 3'd4, 3'd0, cpu_pkg::FN_XOR));
		put_instr(imm5_word(cpu_pkg::OP_LD, 3'd1, 3'd5, 5'd2));
		put_instr(imm5_word(cpu_pkg::OP_ST, 3'd1, 3'd5, 5'd6));
		put_instr(imm5_word(cpu_pkg::OP_LD, 3'd1, 3'd6, 5'd6));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd6, 3'd2, 5'd1));
		run_and_check("store and load", 1'b0);
	endtask

	task automatic branch_cases();
		logic [7:0] v;
		// Odd and positive, so r4 and r4+1 are both nonzero
		v = (rand_byte() & 8'h3e) | 8'h01;
		clear_program();
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd1, 8'h00));
		put_instr(imm8_word(cpu_pkg::OP_BEQZ, 3'd1, 8'd4));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd2, 8'h11));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd3, 8'h22));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd4, v));
		put_instr(imm8_word(cpu_pkg::OP_BEQZ, 3'd4, 8'd4));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd4, 3'd5, 5'd1));
		put_instr(imm8_word(cpu_pkg::OP_BNEZ, 3'd5, 8'd2));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd6, 8'h33));
		put_instr(alu_word(3'd5, 3'd5, 3'd7, cpu_pkg::FN_SUB));
		put_instr(imm8_word(cpu_pkg::OP_BNEZ, 3'd7, 8'd4));
		put_instr(imm8_word(cpu_pkg::OP_BEQZ, 3'd7, 8'd4));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd0, 8'h44));
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd1, 8'h55));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd7, 3'd0, 5'd5));
		run_and_check("branches", 1'b0);
	endtask

	task automatic halt_stop();
		clear_program();
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd1, rand_byte()));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd1, 3'd2, 5'd3));
		put_instr(alu_word(3'd1, 3'd2, 3'd3, cpu_pkg::FN_XOR));
		put_instr({cpu_pkg::OP_HALT, 11'd0});
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd4, 8'h7f));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd4, 3'd5, 5'd1));
		run_and_check("halt", 1'b0);
	endtask

	task automatic bad_opcode();
		clear_program();
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd1, 8'd5));
		put_instr({5'b00100, 3'd1, 3'd1, 5'd3});
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd1, 3'd2, 5'd1));
		put_instr({5'b11111, 3'd2, 3'd1, 3'd2, 2'b00});
		put_instr(alu_word(3'd2, 3'd1, 3'd3, cpu_pkg::FN_ADD));
		run_and_check("unsupported opcode", 1'b1);
		// New program after a fresh reset
		clear_program();
		put_instr(imm8_word(cpu_pkg::OP_LBI, 3'd3, rand_byte()));
		put_instr(alu_word(3'd3, 3'd3, 3'd4, cpu_pkg::FN_ADD));
		put_instr(imm5_word(cpu_pkg::OP_ADDI, 3'd4, 3'd5, 5'h1f));
		run_and_check("rerun after reset", 1'b0);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr_data = '0;
		seed = 32'h327b_eefd;
		errors = 0;
		checks = 0;
		err_cycles = 0;
		clear_program();
		alu_chain();
		store_load();
		branch_cases();
		halt_stop();
		bad_opcode();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [cpu_pkg::DATA_W-1:0]    instr_data,
	output logic [cpu_pkg::DATA_W-1:0]    instr_addr,
	output logic                          err,
	output logic                          halted,
	output logic                          retire_valid,
	output logic [cpu_pkg::REG_SEL_W-1:0] retire_reg,
	output logic [cpu_pkg::DATA_W-1:0]    retire_data
);

	cpu_pkg::instr_t                fd_instr;
	logic [cpu_pkg::DATA_W-1:0]     fd_pc2;
	logic                           load_stall;
	logic                           branch_taken;
	logic [cpu_pkg::DATA_W-1:0]     branch_target;

	// Decode control levels
	logic                           dec_reg_write;
	logic                           dec_mem_read;
	logic                           dec_mem_write;
	logic [cpu_pkg::ALU_OP_W-1:0]   dec_alu_op;
	logic                           dec_use_imm;
	logic                           dec_is_lbi;
	logic                           dec_is_branch;
	logic                           dec_branch_on_zero;
	logic                           dec_uses_rt;
	logic [cpu_pkg::REG_SEL_W-1:0]  dec_dest;
	logic                           dec_halt;
	logic [cpu_pkg::DATA_W-1:0]     rd_data_a;
	logic [cpu_pkg::DATA_W-1:0]     rd_data_b;

	logic [cpu_pkg::FWD_W-1:0]      fwd_a_sel;
	logic [cpu_pkg::FWD_W-1:0]      fwd_b_sel;
	logic [cpu_pkg::REG_SEL_W-1:0]  ex_rs;
	logic [cpu_pkg::REG_SEL_W-1:0]  ex_rt;
	logic [cpu_pkg::REG_SEL_W-1:0]  ex_dest;
	logic                           ex_reg_write;
	logic                           ex_mem_read;

	logic [cpu_pkg::DATA_W-1:0]     mem_addr;
	logic [cpu_pkg::DATA_W-1:0]     mem_wdata;
	logic [cpu_pkg::DATA_W-1:0]     mem_result;
	logic [cpu_pkg::REG_SEL_W-1:0]  mem_dest;
	logic                           mem_reg_write;
	logic                           mem_read;
	logic                           mem_write;
	logic                           mem_halt;

	logic                           wb_write_en;
	logic [cpu_pkg::REG_SEL_W-1:0]  wb_reg;
	logic [cpu_pkg::DATA_W-1:0]     wb_data;

	fetch_stage fetch_stage_i (
		.clk           (clk),
		.reset         (reset),
		.instr_data    (instr_data),
		.load_stall    (load_stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.dec_halt      (dec_halt),
		.instr_addr    (instr_addr),
		.fd_instr      (fd_instr),
		.fd_pc2        (fd_pc2)
	);

	decode_ctrl decode_ctrl_i (
		.fd_instr       (fd_instr),
		.reg_write      (dec_reg_write),
		.mem_read       (dec_mem_read),
		.mem_write      (dec_mem_write),
		.alu_op         (dec_alu_op),
		.use_imm        (dec_use_imm),
		.is_lbi         (dec_is_lbi),
		.is_branch      (dec_is_branch),
		.branch_on_zero (dec_branch_on_zero),
		.uses_rt        (dec_uses_rt),
		.dest_reg       (dec_dest),
		.dec_halt       (dec_halt),
		.err            (err)
	);

	// ST data register shares the rt bit positions
	reg_file reg_file_i (
		.clk         (clk),
		.reset       (reset),
		.rd_sel_a    (fd_instr.r.rs),
		.rd_sel_b    (fd_instr.r.rt),
		.wb_write_en (wb_write_en),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b)
	);

	hazard_unit hazard_unit_i (
		.dec_rs        (fd_instr.r.rs),
		.dec_rt        (fd_instr.r.rt),
		.dec_uses_rt   (dec_uses_rt),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.mem_dest      (mem_dest),
		.mem_reg_write (mem_reg_write),
		.wb_reg        (wb_reg),
		.wb_write_en   (wb_write_en),
		.fwd_a_sel     (fwd_a_sel),
		.fwd_b_sel     (fwd_b_sel),
		.load_stall    (load_stall)
	);

	execute_stage execute_stage_i (
		.clk                (clk),
		.reset              (reset),
		.load_stall         (load_stall),
		.fwd_a_sel          (fwd_a_sel),
		.fwd_b_sel          (fwd_b_sel),
		.dec_reg_write      (dec_reg_write),
		.dec_mem_read       (dec_mem_read),
		.dec_mem_write      (dec_mem_write),
		.dec_alu_op         (dec_alu_op),
		.dec_use_imm        (dec_use_imm),
		.dec_is_lbi         (dec_is_lbi),
		.dec_is_branch      (dec_is_branch),
		.dec_branch_on_zero (dec_branch_on_zero),
		.dec_dest           (dec_dest),
		.dec_halt           (dec_halt),
		.fd_instr           (fd_instr),
		.fd_pc2             (fd_pc2),
		.rd_data_a          (rd_data_a),
		.rd_data_b          (rd_data_b),
		.wb_data            (wb_data),
		.ex_rs              (ex_rs),
		.ex_rt              (ex_rt),
		.ex_dest            (ex_dest),
		.ex_reg_write       (ex_reg_write),
		.ex_mem_read        (ex_mem_read),
		.branch_taken       (branch_taken),
		.branch_target      (branch_target),
		.mem_addr           (mem_addr),
		.mem_wdata          (mem_wdata),
		.mem_result         (mem_result),
		.mem_dest           (mem_dest),
		.mem_reg_write      (mem_reg_write),
		.mem_read           (mem_read),
		.mem_write          (mem_write),
		.mem_halt           (mem_halt)
	);

	mem_wb_stage mem_wb_stage_i (
		.clk           (clk),
		.reset         (reset),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_result    (mem_result),
		.mem_dest      (mem_dest),
		.mem_reg_write (mem_reg_write),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_halt      (mem_halt),
		.wb_write_en   (wb_write_en),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data),
		.halted        (halted)
	);

	// Register-file write port, seen from outside
	assign retire_valid = wb_write_en;
	assign retire_reg   = wb_reg;
	assign retire_data  = wb_data;

endmodule

// File: rtl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [cpu_pkg::DATA_W-1:0]    mem_addr,
	input  logic [cpu_pkg::DATA_W-1:0]    mem_wdata,
	input  logic [cpu_pkg::DATA_W-1:0]    mem_result,
	input  logic [cpu_pkg::REG_SEL_W-1:0] mem_dest,
	input  logic                          mem_reg_write,
	input  logic                          mem_read,
	input  logic                          mem_write,
	input  logic                          mem_halt,
	output logic                          wb_write_en,
	output logic [cpu_pkg::REG_SEL_W-1:0] wb_reg,
	output logic [cpu_pkg::DATA_W-1:0]    wb_data,
	output logic                          halted
);

	logic [cpu_pkg::DATA_W-1:0]      dmem [2**cpu_pkg::DMEM_ADDR_W];
	logic [cpu_pkg::DMEM_ADDR_W-1:0] dmem_idx;
	logic [cpu_pkg::DATA_W-1:0]      load_data;
	logic [cpu_pkg::DATA_W-1:0]      wb_load;
	logic [cpu_pkg::DATA_W-1:0]      wb_result;
	logic                            wb_is_load;
	logic                            wb_halt;

	// Bit 0 only picks a byte within the halfword
	assign dmem_idx  = mem_addr[cpu_pkg::DMEM_ADDR_W:1];
	assign load_data = dmem[dmem_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**cpu_pkg::DMEM_ADDR_W; i++)
				dmem[i] <= '0;
		end else if (mem_write) begin
			dmem[dmem_idx] <= mem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_write_en <= 1'b0;
			wb_reg      <= '0;
			wb_is_load  <= 1'b0;
			wb_halt     <= 1'b0;
			halted      <= 1'b0;
		end else begin
			wb_write_en <= mem_reg_write;
			wb_reg      <= mem_dest;
			wb_is_load  <= mem_read;
			wb_halt     <= mem_halt;
			// Sticky until the next reset
			if (wb_halt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		wb_result <= mem_result;
		wb_load   <= load_data;
	end

	assign wb_data = wb_is_load ? wb_load : wb_result;

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          load_stall,
	input  logic [cpu_pkg::FWD_W-1:0]     fwd_a_sel,
	input  logic [cpu_pkg::FWD_W-1:0]     fwd_b_sel,
	input  logic                          dec_reg_write,
	input  logic                          dec_mem_read,
	input  logic                          dec_mem_write,
	input  logic [cpu_pkg::ALU_OP_W-1:0]  dec_alu_op,
	input  logic                          dec_use_imm,
	input  logic                          dec_is_lbi,
	input  logic                          dec_is_branch,
	input  logic                          dec_branch_on_zero,
	input  logic [cpu_pkg::REG_SEL_W-1:0] dec_dest,
	input  logic                          dec_halt,
	input  cpu_pkg::instr_t               fd_instr,
	input  logic [cpu_pkg::DATA_W-1:0]    fd_pc2,
	input  logic [cpu_pkg::DATA_W-1:0]    rd_data_a,
	input  logic [cpu_pkg::DATA_W-1:0]    rd_data_b,
	input  logic [cpu_pkg::DATA_W-1:0]    wb_data,
	output logic [cpu_pkg::REG_SEL_W-1:0] ex_rs,
	output logic [cpu_pkg::REG_SEL_W-1:0] ex_rt,
	output logic [cpu_pkg::REG_SEL_W-1:0] ex_dest,
	output logic                          ex_reg_write,
	output logic                          ex_mem_read,
	output logic                          branch_taken,
	output logic [cpu_pkg::DATA_W-1:0]    branch_target,
	output logic [cpu_pkg::DATA_W-1:0]    mem_addr,
	output logic [cpu_pkg::DATA_W-1:0]    mem_wdata,
	output logic [cpu_pkg::DATA_W-1:0]    mem_result,
	output logic [cpu_pkg::REG_SEL_W-1:0] mem_dest,
	output logic                          mem_reg_write,
	output logic                          mem_read,
	output logic                          mem_write,
	output logic                          mem_halt
);

	cpu_pkg::instr_t                ex_instr;
	logic [cpu_pkg::DATA_W-1:0]     ex_pc2;
	logic [cpu_pkg::DATA_W-1:0]     ex_a;
	logic [cpu_pkg::DATA_W-1:0]     ex_b;
	logic                           ex_mem_write;
	logic [cpu_pkg::ALU_OP_W-1:0]   ex_alu_op;
	logic                           ex_use_imm;
	logic                           ex_is_lbi;
	logic                           ex_is_branch;
	logic                           ex_branch_on_zero;
	logic                           ex_halt;
	logic [cpu_pkg::DATA_W-1:0]     op_a;
	logic [cpu_pkg::DATA_W-1:0]     op_b;
	logic [cpu_pkg::DATA_W-1:0]     imm5_ext;
	logic [cpu_pkg::DATA_W-1:0]     imm8_ext;
	logic [cpu_pkg::DATA_W-1:0]     alu_b;
	logic [cpu_pkg::DATA_W-1:0]     alu_out;

	function automatic logic [cpu_pkg::DATA_W-1:0] fwd_mux(
		input logic [cpu_pkg::FWD_W-1:0]  sel,
		input logic [cpu_pkg::DATA_W-1:0] reg_val
	);
		case (sel)
			cpu_pkg::FWD_MEM: return mem_result;
			cpu_pkg::FWD_WB:  return wb_data;
			default:          return reg_val;
		endcase
	endfunction

	// Decode/execute register takes a bubble on stall or squash
	always_ff @(posedge clk) begin
		if (reset || load_stall || branch_taken) begin
			ex_instr          <= cpu_pkg::NOP_WORD;
			ex_dest           <= '0;
			ex_reg_write      <= 1'b0;
			ex_mem_read       <= 1'b0;
			ex_mem_write      <= 1'b0;
			ex_alu_op         <= cpu_pkg::ALU_ADD;
			ex_use_imm        <= 1'b0;
			ex_is_lbi         <= 1'b0;
			ex_is_branch      <= 1'b0;
			ex_branch_on_zero <= 1'b0;
			ex_halt           <= 1'b0;
		end else begin
			ex_instr          <= fd_instr;
			ex_dest           <= dec_dest;
			ex_reg_write      <= dec_reg_write;
			ex_mem_read       <= dec_mem_read;
			ex_mem_write      <= dec_mem_write;
			ex_alu_op         <= dec_alu_op;
			ex_use_imm        <= dec_use_imm;
			ex_is_lbi         <= dec_is_lbi;
			ex_is_branch      <= dec_is_branch;
			ex_branch_on_zero <= dec_branch_on_zero;
			ex_halt           <= dec_halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc2 <= fd_pc2;
		ex_a   <= rd_data_a;
		ex_b   <= rd_data_b;
	end

	assign ex_rs = ex_instr.r.rs;
	assign ex_rt = ex_instr.r.rt;

	always_comb begin
		op_a = fwd_mux(fwd_a_sel, ex_a);
		op_b = fwd_mux(fwd_b_sel, ex_b);
	end

	assign imm5_ext = {{(cpu_pkg::DATA_W-cpu_pkg::IMM5_W){ex_instr.i.imm5[cpu_pkg::IMM5_W-1]}},
		ex_instr.i.imm5};
	assign imm8_ext = {{(cpu_pkg::DATA_W-cpu_pkg::IMM8_W){ex_instr.l.imm8[cpu_pkg::IMM8_W-1]}},
		ex_instr.l.imm8};
	assign alu_b = ex_is_lbi ? imm8_ext : (ex_use_imm ? imm5_ext : op_b);

	always_comb begin
		case (ex_alu_op)
			cpu_pkg::ALU_ADD:  alu_out = op_a + alu_b;
			// rt minus rs
			cpu_pkg::ALU_SUB:  alu_out = alu_b - op_a;
			cpu_pkg::ALU_XOR:  alu_out = op_a ^ alu_b;
			cpu_pkg::ALU_ANDN: alu_out = op_a & ~alu_b;
			default:           alu_out = alu_b;
		endcase
	end

	// Branches test forwarded rs and resolve here
	assign branch_taken  = ex_is_branch && ((op_a == '0) == ex_branch_on_zero);
	assign branch_target = ex_pc2 + imm8_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_dest      <= '0;
			mem_reg_write <= 1'b0;
			mem_read      <= 1'b0;
			mem_write     <= 1'b0;
			mem_halt      <= 1'b0;
		end else begin
			mem_dest      <= ex_dest;
			mem_reg_write <= ex_reg_write;
			mem_read      <= ex_mem_read;
			mem_write     <= ex_mem_write;
			mem_halt      <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_result <= alu_out;
		mem_wdata  <= op_b;
	end

	// Loads and stores use the ALU sum as address
	assign mem_addr = mem_result;

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  logic [cpu_pkg::REG_SEL_W-1:0] dec_rs,
	input  logic [cpu_pkg::REG_SEL_W-1:0] dec_rt,
	input  logic                          dec_uses_rt,
	input  logic [cpu_pkg::REG_SEL_W-1:0] ex_rs,
	input  logic [cpu_pkg::REG_SEL_W-1:0] ex_rt,
	input  logic [cpu_pkg::REG_SEL_W-1:0] ex_dest,
	input  logic                          ex_reg_write,
	input  logic                          ex_mem_read,
	input  logic [cpu_pkg::REG_SEL_W-1:0] mem_dest,
	input  logic                          mem_reg_write,
	input  logic [cpu_pkg::REG_SEL_W-1:0] wb_reg,
	input  logic                          wb_write_en,
	output logic [cpu_pkg::FWD_W-1:0]     fwd_a_sel,
	output logic [cpu_pkg::FWD_W-1:0]     fwd_b_sel,
	output logic                          load_stall
);

	// Younger result in memory stage wins over writeback
	always_comb begin
		fwd_a_sel = cpu_pkg::FWD_NONE;
		if (mem_reg_write && mem_dest == ex_rs)
			fwd_a_sel = cpu_pkg::FWD_MEM;
		else if (wb_write_en && wb_reg == ex_rs)
			fwd_a_sel = cpu_pkg::FWD_WB;

		fwd_b_sel = cpu_pkg::FWD_NONE;
		if (mem_reg_write && mem_dest == ex_rt)
			fwd_b_sel = cpu_pkg::FWD_MEM;
		else if (wb_write_en && wb_reg == ex_rt)
			fwd_b_sel = cpu_pkg::FWD_WB;
	end

	// Load data is only ready from writeback, so hold decode one cycle
	assign load_stall = ex_mem_read && ex_reg_write &&
		(ex_dest == dec_rs || (dec_uses_rt && ex_dest == dec_rt));

endmodule

// File: decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [cpu_pkg::REG_SEL_W-1:0] rd_sel_a,
	input  logic [cpu_pkg::REG_SEL_W-1:0] rd_sel_b,
	input  logic                          wb_write_en,
	input  logic [cpu_pkg::REG_SEL_W-1:0] wb_reg,
	input  logic [cpu_pkg::DATA_W-1:0]    wb_data,
	output logic [cpu_pkg::DATA_W-1:0]    rd_data_a,
	output logic [cpu_pkg::DATA_W-1:0]    rd_data_b
);

	logic [cpu_pkg::DATA_W-1:0] regs [2**cpu_pkg::REG_SEL_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**cpu_pkg::REG_SEL_W; i++)
				regs[i] <= '0;
		end else if (wb_write_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write-through lets decode see the value retiring this cycle
	assign rd_data_a = (wb_write_en && wb_reg == rd_sel_a) ? wb_data : regs[rd_sel_a];
	assign rd_data_b = (wb_write_en && wb_reg == rd_sel_b) ? wb_data : regs[rd_sel_b];

endmodule

// File: decode/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
	input  cpu_pkg::instr_t                fd_instr,
	output logic                           reg_write,
	output logic                           mem_read,
	output logic                           mem_write,
	output logic [cpu_pkg::ALU_OP_W-1:0]   alu_op,
	output logic                           use_imm,
	output logic                           is_lbi,
	output logic                           is_branch,
	output logic                           branch_on_zero,
	output logic                           uses_rt,
	output logic [cpu_pkg::REG_SEL_W-1:0]  dest_reg,
	output logic                           dec_halt,
	output logic                           err
);

	always_comb begin
		reg_write      = 1'b0;
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		alu_op         = cpu_pkg::ALU_ADD;
		use_imm        = 1'b0;
		is_lbi         = 1'b0;
		is_branch      = 1'b0;
		branch_on_zero = 1'b0;
		uses_rt        = 1'b0;
		dest_reg       = '0;
		dec_halt       = 1'b0;
		err            = 1'b0;

		case (fd_instr.r.opcode)
			cpu_pkg::OP_HALT: dec_halt = 1'b1;
			cpu_pkg::OP_NOP:  dec_halt = 1'b0;
			cpu_pkg::OP_ADDI: begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				dest_reg  = fd_instr.i.rd;
			end
			cpu_pkg::OP_LBI: begin
				// LBI writes back into its own rs field
				reg_write = 1'b1;
				is_lbi    = 1'b1;
				alu_op    = cpu_pkg::ALU_PASS_B;
				dest_reg  = fd_instr.l.rs;
			end
			cpu_pkg::OP_ST: begin
				// Store data register sits where rt is in R-format
				mem_write = 1'b1;
				use_imm   = 1'b1;
				uses_rt   = 1'b1;
			end
			cpu_pkg::OP_LD: begin
				mem_read  = 1'b1;
				reg_write = 1'b1;
				use_imm   = 1'b1;
				dest_reg  = fd_instr.i.rd;
			end
			cpu_pkg::OP_BEQZ: begin
				is_branch      = 1'b1;
				branch_on_zero = 1'b1;
			end
			cpu_pkg::OP_BNEZ: is_branch = 1'b1;
			cpu_pkg::OP_ALU: begin
				reg_write = 1'b1;
				uses_rt   = 1'b1;
				dest_reg  = fd_instr.r.rd;
				case (fd_instr.r.funct)
					cpu_pkg::FN_ADD:  alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUB:  alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_ANDN: alu_op = cpu_pkg::ALU_ANDN;
				endcase
			end
			// Anything else moves on as a NOP
			default: err = 1'b1;
		endcase
	end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [cpu_pkg::DATA_W-1:0] instr_data,
	input  logic                       load_stall,
	input  logic                       branch_taken,
	input  logic [cpu_pkg::DATA_W-1:0] branch_target,
	input  logic                       dec_halt,
	output logic [cpu_pkg::DATA_W-1:0] instr_addr,
	output cpu_pkg::instr_t            fd_instr,
	output logic [cpu_pkg::DATA_W-1:0] fd_pc2
);

	logic [cpu_pkg::DATA_W-1:0] pc;
	logic [cpu_pkg::DATA_W-1:0] pc2;
	// Set once HALT has left decode
	logic stop;

	assign instr_addr = pc;
	assign pc2        = pc + cpu_pkg::PC_STEP;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc       <= '0;
			stop     <= 1'b0;
			fd_instr <= cpu_pkg::NOP_WORD;
		end else if (branch_taken) begin
			// Redirect and drop the word fetched this cycle
			pc       <= branch_target;
			stop     <= 1'b0;
			fd_instr <= cpu_pkg::NOP_WORD;
		end else if (load_stall) begin
			pc       <= pc;
			fd_instr <= fd_instr;
		end else if (stop || dec_halt) begin
			stop     <= 1'b1;
			fd_instr <= cpu_pkg::NOP_WORD;
		end else begin
			pc       <= pc2;
			fd_instr <= cpu_pkg::instr_t'(instr_data);
		end
	end

	always_ff @(posedge clk) begin
		if (!load_stall)
			fd_pc2 <= pc2;
	end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W      = 16;
	localparam int REG_SEL_W   = 3;
	localparam int DMEM_ADDR_W = 8;
	localparam int OP_W        = 5;
	localparam int FN_W        = 2;
	localparam int IMM5_W      = 5;
	localparam int IMM8_W      = 8;

	// Halfword addressing
	localparam logic [DATA_W-1:0] PC_STEP = 16'd2;

	// Opcodes sit in the top five bits of every format
	localparam logic [OP_W-1:0] OP_HALT = 5'b00000;
	localparam logic [OP_W-1:0] OP_NOP  = 5'b00001;
	localparam logic [OP_W-1:0] OP_ADDI = 5'b01000;
	localparam logic [OP_W-1:0] OP_BEQZ = 5'b01100;
	localparam logic [OP_W-1:0] OP_BNEZ = 5'b01101;
	localparam logic [OP_W-1:0] OP_ST   = 5'b10000;
	localparam logic [OP_W-1:0] OP_LD   = 5'b10001;
	localparam logic [OP_W-1:0] OP_LBI  = 5'b11000;
	localparam logic [OP_W-1:0] OP_ALU  = 5'b11011;

	localparam logic [FN_W-1:0] FN_ADD  = 2'b00;
	localparam logic [FN_W-1:0] FN_SUB  = 2'b01;
	localparam logic [FN_W-1:0] FN_XOR  = 2'b10;
	localparam logic [FN_W-1:0] FN_ANDN = 2'b11;

	localparam int ALU_OP_W = 3;
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_ANDN   = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd4;

	// Where an execute operand comes from
	localparam int FWD_W = 2;
	localparam logic [FWD_W-1:0] FWD_NONE = 2'd0;
	localparam logic [FWD_W-1:0] FWD_MEM  = 2'd1;
	localparam logic [FWD_W-1:0] FWD_WB   = 2'd2;

	typedef union packed {
		struct packed {
			logic [OP_W-1:0]      opcode;
			logic [REG_SEL_W-1:0] rs;
			logic [REG_SEL_W-1:0] rt;
			logic [REG_SEL_W-1:0] rd;
			logic [FN_W-1:0]      funct;
		} r;
		struct packed {
			logic [OP_W-1:0]      opcode;
			logic [REG_SEL_W-1:0] rs;
			logic [REG_SEL_W-1:0] rd;
			logic [IMM5_W-1:0]    imm5;
		} i;
		struct packed {
			logic [OP_W-1:0]      opcode;
			logic [REG_SEL_W-1:0] rs;
			logic [IMM8_W-1:0]    imm8;
		} l;
	} instr_t;

	// Squashed slots carry this
	localparam instr_t NOP_WORD = instr_t'({OP_NOP, {(DATA_W-OP_W){1'b0}}});

endpackage
